//--- hw/control_encoder.sv
`timescale 1ns/100ps

module control_encoder (
  input  logic                      clk,
  input  logic                      reset,
  input  mcu_ctrl_pkg::exec_state_e state,
  input  mcu_ctrl_pkg::step_t       step,
  output logic                      alu_src_a,
  output mcu_ctrl_pkg::alu_src_b_e  alu_src_b,
  output mcu_ctrl_pkg::alu_op_e     alu_op,
  output mcu_ctrl_pkg::pc_source_e  pc_source,
  output logic                      ir_write,
  output logic                      pc_write,
  output mcu_ctrl_pkg::reg_dst_e    reg_dst,
  output mcu_ctrl_pkg::wb_source_e  wb_source,
  output logic                      reg_write,
  output logic                      a_write,
  output logic                      b_write,
  output logic                      alu_out_write
);
  import mcu_ctrl_pkg::*;

  alu_op_e arith_op;

  // ALU op shared by the add, sub and and sequences
  always_comb begin
    case (state)
      ST_SUB:  arith_op = ALU_SUB;
      ST_AND:  arith_op = ALU_AND;
      default: arith_op = ALU_ADD;
    endcase
  end

  always_ff @(posedge clk) begin
    // Idle word, overridden below per state and step
    alu_src_a     <= 1'b0;
    alu_src_b     <= SRCB_REG_B;
    alu_op        <= ALU_NONE;
    pc_source     <= PC_ALU;
    ir_write      <= 1'b0;
    pc_write      <= 1'b0;
    reg_dst       <= REG_DST_RT;
    wb_source     <= WB_NONE;
    reg_write     <= 1'b0;
    a_write       <= 1'b0;
    b_write       <= 1'b0;
    alu_out_write <= 1'b0;
    if (!reset) begin
      case (state)
        ST_FETCH: begin
          // PC + 4 on steps 0 to 2, step 3 is decode
          if (step != 2'd3) begin
            alu_src_b <= SRCB_FOUR;
            alu_op    <= ALU_ADD;
          end
          if (step == 2'd2) begin
            ir_write <= 1'b1;
            pc_write <= 1'b1;
          end
        end
        ST_ADD, ST_SUB, ST_AND: begin
          if (step == 2'd0) begin
            a_write <= 1'b1;
            b_write <= 1'b1;
          end else begin
            alu_src_a <= 1'b1;
            alu_op    <= arith_op;
          end
          if (step == 2'd1) begin
            alu_out_write <= 1'b1;
          end
          if (step == 2'd2) begin
            reg_dst   <= REG_DST_RD;
            wb_source <= WB_ALUOUT;
            reg_write <= 1'b1;
          end
        end
        ST_XCHG: begin
          if (step == 2'd0) begin
            a_write <= 1'b1;
            b_write <= 1'b1;
          end else if (step == 2'd1) begin
            reg_dst   <= REG_DST_RT;
            wb_source <= WB_REG_A;
            reg_write <= 1'b1;
          end else begin
            reg_dst   <= REG_DST_RS;
            wb_source <= WB_REG_B;
            reg_write <= 1'b1;
          end
        end
        ST_JR: begin
          a_write <= 1'b1;
          if (step == 2'd1) begin
            pc_source <= PC_REG_A;
            pc_write  <= 1'b1;
          end
        end
        ST_BREAK: begin
          // PC - 4 back onto the break instruction
          alu_src_b <= SRCB_FOUR;
          alu_op    <= ALU_SUB;
          pc_source <= PC_ALU;
          pc_write  <= 1'b1;
        end
        ST_RTE: begin
          pc_source <= PC_EPC;
          pc_write  <= 1'b1;
        end
        ST_MFHI, ST_MFLO: begin
          reg_dst   <= REG_DST_RD;
          wb_source <= (state == ST_MFHI) ? WB_HI : WB_LO;
          reg_write <= 1'b1;
        end
        default: begin
          reg_write <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- hw/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
  input  logic [5:0]                opcode,
  input  logic [5:0]                funct,
  output mcu_ctrl_pkg::exec_state_e next_state
);
  import mcu_ctrl_pkg::*;

  exec_state_e funct_state;

  // Execution state per supported funct code
  always_comb begin
    case (funct)
      FUNCT_ADD: begin
        funct_state = ST_ADD;
      end
      FUNCT_SUB: begin
        funct_state = ST_SUB;
      end
      FUNCT_AND: begin
        funct_state = ST_AND;
      end
      FUNCT_XCHG: begin
        funct_state = ST_XCHG;
      end
      FUNCT_JR: begin
        funct_state = ST_JR;
      end
      FUNCT_MFHI: begin
        funct_state = ST_MFHI;
      end
      FUNCT_MFLO: begin
        funct_state = ST_MFLO;
      end
      FUNCT_BREAK: begin
        funct_state = ST_BREAK;
      end
      FUNCT_RTE: begin
        funct_state = ST_RTE;
      end
      default: begin
        funct_state = ST_FETCH;
      end
    endcase
  end

  // Anything outside R-type falls back to fetch
  always_comb begin
    if (opcode == OPCODE_R_TYPE) begin
      next_state = funct_state;
    end else begin
      next_state = ST_FETCH;
    end
  end

endmodule

//--- hw/mcu_ctrl_pkg.sv
package mcu_ctrl_pkg;

  // R-type instructions share opcode zero and are told apart by funct
  localparam logic [5:0] OPCODE_R_TYPE = 6'b000000;

  typedef enum logic [5:0] {
    FUNCT_ADD   = 6'b100000,
    FUNCT_AND   = 6'b100100,
    FUNCT_SUB   = 6'b100010,
    FUNCT_XCHG  = 6'b000101,
    FUNCT_JR    = 6'b001000,
    FUNCT_MFHI  = 6'b010000,
    FUNCT_MFLO  = 6'b010010,
    FUNCT_BREAK = 6'b001101,
    FUNCT_RTE   = 6'b010011
  } funct_e;

  // Fetch holds the four fetch and decode steps
  typedef enum logic [3:0] {
    ST_FETCH = 4'd0,
    ST_ADD   = 4'd1,
    ST_SUB   = 4'd2,
    ST_AND   = 4'd3,
    ST_XCHG  = 4'd4,
    ST_JR    = 4'd5,
    ST_MFHI  = 4'd6,
    ST_MFLO  = 4'd7,
    ST_BREAK = 4'd8,
    ST_RTE   = 4'd9
  } exec_state_e;

  typedef logic [1:0] step_t;

  typedef enum logic [2:0] {
    ALU_NONE = 3'b000,
    ALU_ADD  = 3'b001,
    ALU_SUB  = 3'b010,
    ALU_AND  = 3'b011
  } alu_op_e;

  typedef enum logic [1:0] {
    SRCB_REG_B = 2'b00,
    SRCB_FOUR  = 2'b01
  } alu_src_b_e;

  typedef enum logic [2:0] {
    PC_ALU   = 3'b000,
    PC_EPC   = 3'b001,
    PC_REG_A = 3'b011
  } pc_source_e;

  typedef enum logic [2:0] {
    REG_DST_RT = 3'b000,
    REG_DST_RS = 3'b001,
    REG_DST_RD = 3'b011
  } reg_dst_e;

  // Register file write data select
  typedef enum logic [3:0] {
    WB_NONE   = 4'b0000,
    WB_REG_B  = 4'b0001,
    WB_ALUOUT = 4'b0010,
    WB_REG_A  = 4'b0100,
    WB_HI     = 4'b1000,
    WB_LO     = 4'b1001
  } wb_source_e;

endpackage

//--- hw/multicycle_ctrl.sv
`timescale 1ns/100ps

module multicycle_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [5:0]               opcode,
  input  logic [5:0]               funct,
  output logic                     alu_src_a,
  output mcu_ctrl_pkg::alu_src_b_e alu_src_b,
  output mcu_ctrl_pkg::alu_op_e    alu_op,
  output mcu_ctrl_pkg::pc_source_e pc_source,
  output logic                     ir_write,
  output logic                     pc_write,
  output mcu_ctrl_pkg::reg_dst_e   reg_dst,
  output mcu_ctrl_pkg::wb_source_e wb_source,
  output logic                     reg_write,
  output logic                     a_write,
  output logic                     b_write,
  output logic                     alu_out_write
);
  import mcu_ctrl_pkg::*;

  exec_state_e next_state;
  exec_state_e state;
  step_t       step;

  instr_decoder u_instr_decoder (
    .opcode     (opcode),
    .funct      (funct),
    .next_state (next_state)
  );

  step_sequencer u_step_sequencer (
    .clk        (clk),
    .reset      (reset),
    .next_state (next_state),
    .state      (state),
    .step       (step)
  );

  // Outputs lag state and step by one clock
  control_encoder u_control_encoder (
    .clk           (clk),
    .reset         (reset),
    .state         (state),
    .step          (step),
    .alu_src_a     (alu_src_a),
    .alu_src_b     (alu_src_b),
    .alu_op        (alu_op),
    .pc_source     (pc_source),
    .ir_write      (ir_write),
    .pc_write      (pc_write),
    .reg_dst       (reg_dst),
    .wb_source     (wb_source),
    .reg_write     (reg_write),
    .a_write       (a_write),
    .b_write       (b_write),
    .alu_out_write (alu_out_write)
  );

endmodule

//--- hw/step_sequencer.sv
`timescale 1ns/100ps

module step_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  mcu_ctrl_pkg::exec_state_e next_state,
  output mcu_ctrl_pkg::exec_state_e state,
  output mcu_ctrl_pkg::step_t       step
);
  import mcu_ctrl_pkg::*;

  step_t last_step;

  // Final step index of each sequence
  always_comb begin
    case (state)
      ST_FETCH: begin
        last_step = 2'd3;
      end
      ST_ADD, ST_SUB, ST_AND, ST_XCHG: begin
        last_step = 2'd2;
      end
      ST_JR: begin
        last_step = 2'd1;
      end
      default: begin
        last_step = 2'd0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_FETCH;
      step  <= 2'd0;
    end else if (step != last_step) begin
      step <= step + 2'd1;
    end else if (state == ST_FETCH) begin
      // Decode cycle, unsupported codes come back as fetch
      state <= next_state;
      step  <= 2'd0;
    end else begin
      state <= ST_FETCH;
      step  <= 2'd0;
    end
  end

endmodule

//--- project.f
hw/mcu_ctrl_pkg.sv
hw/instr_decoder.sv
hw/step_sequencer.sv
hw/control_encoder.sv
hw/multicycle_ctrl.sv
verification/multicycle_ctrl_props.sv
verification/multicycle_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the multicycle controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -f project.f --top-module multicycle_ctrl_tb -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Let assertion failures reach the final report of the testbench
./obj_dir/sim_tb +verilator+error+limit+1000 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

grep -q "^Finished with no errors$" "$log_file"
if [ $? -ne 0 ]; then
  echo "Simulation failed"
  exit 1
fi

echo "Simulation passed"
exit 0

//--- verification/multicycle_ctrl_props.sv
`timescale 1ns/100ps

module multicycle_ctrl_props (
  input logic                     clk,
  input logic                     reset,
  input logic [21:0]              ctrl_word,
  input logic                     ir_write,
  input logic                     pc_write,
  input logic                     reg_write,
  input logic                     alu_out_write,
  input mcu_ctrl_pkg::wb_source_e wb_source
);
  import mcu_ctrl_pkg::*;

  int violations = 0;

  // Word registered during reset must be all zero
  reset_clears_outputs: assert property (@(posedge clk) reset |=> ctrl_word == '0)
    else begin
      $error("control outputs not cleared during reset");
      violations++;
    end

  ir_write_with_pc_write: assert property (
    @(posedge clk) disable iff (reset) ir_write |-> pc_write)
    else begin
      $error("ir_write without pc_write");
      violations++;
    end

  no_reg_and_pc_write: assert property (
    @(posedge clk) disable iff (reset) !(reg_write && pc_write))
    else begin
      $error("reg_write and pc_write in the same cycle");
      violations++;
    end

  // ALU result written back one cycle later
  alu_out_then_writeback: assert property (
    @(posedge clk) disable iff (reset)
    alu_out_write |=> (reg_write && wb_source == WB_ALUOUT))
    else begin
      $error("alu_out_write not followed by an ALU writeback");
      violations++;
    end

endmodule

bind multicycle_ctrl multicycle_ctrl_props u_props (
  .clk           (clk),
  .reset         (reset),
  .ctrl_word     ({alu_src_a, alu_src_b, alu_op, pc_source, ir_write, pc_write, reg_dst,
                   wb_source, reg_write, a_write, b_write, alu_out_write}),
  .ir_write      (ir_write),
  .pc_write      (pc_write),
  .reg_write     (reg_write),
  .alu_out_write (alu_out_write),
  .wb_source     (wb_source)
);

//--- verification/multicycle_ctrl_tb.sv
`timescale 1ns/100ps

module multicycle_ctrl_tb;
  import mcu_ctrl_pkg::*;

  localparam int NUM_ROWS     = 14;
  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int WATCHDOG_NS  = (NUM_ROWS * 8 + RESET_CYCLES) * CLK_PERIOD;

  // Expected {reg_dst, wb_source} pairs
  localparam logic [6:0] NO_PAIR   = 7'd0;
  localparam logic [6:0] RD_ALUOUT = {REG_DST_RD, WB_ALUOUT};
  localparam logic [6:0] RT_REG_A  = {REG_DST_RT, WB_REG_A};
  localparam logic [6:0] RS_REG_B  = {REG_DST_RS, WB_REG_B};
  localparam logic [6:0] RD_HI     = {REG_DST_RD, WB_HI};
  localparam logic [6:0] RD_LO     = {REG_DST_RD, WB_LO};
  localparam logic [21:0] FETCH_WORD = {1'b0, SRCB_FOUR, ALU_ADD, PC_ALU, 2'b00, REG_DST_RT,
                                        WB_NONE, 4'b0000};

  logic       clk;
  logic       reset;
  logic [5:0] opcode;
  logic [5:0] funct;
  logic       alu_src_a;
  alu_src_b_e alu_src_b;
  alu_op_e    alu_op;
  pc_source_e pc_source;
  logic       ir_write;
  logic       pc_write;
  reg_dst_e   reg_dst;
  wb_source_e wb_source;
  logic       reg_write;
  logic       a_write;
  logic       b_write;
  logic       alu_out_write;

  // Stimulus table
  string      row_name [NUM_ROWS];
  logic [5:0] row_opcode [NUM_ROWS];
  logic [5:0] row_funct [NUM_ROWS];
  int         row_len [NUM_ROWS];
  int         row_reg_writes [NUM_ROWS];
  int         row_pc_writes [NUM_ROWS];
  int         row_alu_writes [NUM_ROWS];
  logic [2:0] row_alu_op [NUM_ROWS];
  logic [2:0] row_pc_source [NUM_ROWS];
  logic [6:0] row_pair0 [NUM_ROWS];
  logic [6:0] row_pair1 [NUM_ROWS];
  int         num_loaded = 0;

  // Signature of the last execution window
  int         win_cycles;
  int         win_reg;
  int         win_pc;
  int         win_alu;
  logic [2:0] win_op;
  logic [2:0] win_pcs;
  logic [6:0] win_pair [2];

  int row_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  multicycle_ctrl DUT (
    .clk           (clk),
    .reset         (reset),
    .opcode        (opcode),
    .funct         (funct),
    .alu_src_a     (alu_src_a),
    .alu_src_b     (alu_src_b),
    .alu_op        (alu_op),
    .pc_source     (pc_source),
    .ir_write      (ir_write),
    .pc_write      (pc_write),
    .reg_dst       (reg_dst),
    .wb_source     (wb_source),
    .reg_write     (reg_write),
    .a_write       (a_write),
    .b_write       (b_write),
    .alu_out_write (alu_out_write)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the DUT stopped producing ir_write pulses", WATCHDOG_NS);
    $display("Finished with errors");
    $finish;
  end

  task automatic add_row(string name, logic [5:0] op, logic [5:0] fn, int len, int rw, int pw,
                         int aw, logic [2:0] alu, logic [2:0] pcs, logic [6:0] p0,
                         logic [6:0] p1);
    row_name[num_loaded]       = name;
    row_opcode[num_loaded]     = op;
    row_funct[num_loaded]      = fn;
    row_len[num_loaded]        = len;
    row_reg_writes[num_loaded] = rw;
    row_pc_writes[num_loaded]  = pw;
    row_alu_writes[num_loaded] = aw;
    row_alu_op[num_loaded]     = alu;
    row_pc_source[num_loaded]  = pcs;
    row_pair0[num_loaded]      = p0;
    row_pair1[num_loaded]      = p1;
    num_loaded++;
  endtask

  task automatic load_table();
    logic [5:0] r;
    r = OPCODE_R_TYPE;
    // name, opcode, funct, length, reg/pc/alu_out writes, alu_op, pc_source, pairs
    add_row("ADD", r, FUNCT_ADD, 3, 1, 0, 1, ALU_ADD, PC_ALU, RD_ALUOUT, NO_PAIR);
    add_row("SUB", r, FUNCT_SUB, 3, 1, 0, 1, ALU_SUB, PC_ALU, RD_ALUOUT, NO_PAIR);
    add_row("AND", r, FUNCT_AND, 3, 1, 0, 1, ALU_AND, PC_ALU, RD_ALUOUT, NO_PAIR);
    add_row("XCHG", r, FUNCT_XCHG, 3, 2, 0, 0, ALU_NONE, PC_ALU, RT_REG_A, RS_REG_B);
    add_row("JR", r, FUNCT_JR, 2, 0, 1, 0, ALU_NONE, PC_REG_A, NO_PAIR, NO_PAIR);
    add_row("MFHI", r, FUNCT_MFHI, 1, 1, 0, 0, ALU_NONE, PC_ALU, RD_HI, NO_PAIR);
    add_row("MFLO", r, FUNCT_MFLO, 1, 1, 0, 0, ALU_NONE, PC_ALU, RD_LO, NO_PAIR);
    add_row("BREAK", r, FUNCT_BREAK, 1, 0, 1, 0, ALU_SUB, PC_ALU, NO_PAIR, NO_PAIR);
    add_row("RTE", r, FUNCT_RTE, 1, 0, 1, 0, ALU_NONE, PC_EPC, NO_PAIR, NO_PAIR);
    // R-type codes with no sequence of their own
    add_row("MULT", r, 6'b011000, 0, 0, 0, 0, ALU_NONE, PC_ALU, NO_PAIR, NO_PAIR);
    add_row("DIV", r, 6'b011010, 0, 0, 0, 0, ALU_NONE, PC_ALU, NO_PAIR, NO_PAIR);
    add_row("RAND_OP_A", 6'(1 + $urandom % 63), FUNCT_ADD, 0, 0, 0, 0, ALU_NONE, PC_ALU,
            NO_PAIR, NO_PAIR);
    add_row("RAND_OP_B", 6'(1 + $urandom % 63), FUNCT_JR, 0, 0, 0, 0, ALU_NONE, PC_ALU,
            NO_PAIR, NO_PAIR);
    add_row("ADD_AGAIN", r, FUNCT_ADD, 3, 1, 0, 1, ALU_ADD, PC_ALU, RD_ALUOUT, NO_PAIR);
  endtask

  function automatic logic [21:0] output_word();
    return {alu_src_a, alu_src_b, alu_op, pc_source, ir_write, pc_write, reg_dst, wb_source,
            reg_write, a_write, b_write, alu_out_write};
  endfunction

  task automatic compare_field(string test, string field, int expected, int actual);
    assert (expected == actual) else begin
      $display("FAILED %s %s: expected %0d, actual %0d", test, field, expected, actual);
      row_errors++;
    end
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (row_errors == 0) begin
      $display("PASSED %s", name);
    end else begin
      tests_failed++;
      $display("%s: %0d mismatches", name, row_errors);
    end
    row_errors = 0;
  endtask

  // Decode cycle, execution and fetch steps 0 and 1 up to the next ir_write
  task automatic collect_window();
    win_cycles = 0;
    win_reg = 0;
    win_pc = 0;
    win_alu = 0;
    win_op = ALU_NONE;
    win_pcs = PC_ALU;
    win_pair[0] = NO_PAIR;
    win_pair[1] = NO_PAIR;
    @(negedge clk);
    while (!ir_write) begin
      win_cycles++;
      if (reg_write) begin
        if (win_reg < 2) begin
          win_pair[win_reg] = {reg_dst, wb_source};
        end
        win_reg++;
      end
      if (pc_write) begin
        win_pc++;
        win_pcs = pc_source;
        win_op = alu_op;
      end
      if (alu_out_write) begin
        win_alu++;
        win_op = alu_op;
      end
      @(negedge clk);
    end
  endtask

  initial begin
    logic [21:0] word;
    void'($urandom(32'h3f16));
    load_table();
    reset <= 1'b1;
    opcode <= '0;
    funct <= '0;
    repeat (RESET_CYCLES - 1) begin
      @(negedge clk);
      compare_field("RESET", "word during reset", 0, int'(output_word()));
    end
    @(posedge clk);
    reset <= 1'b0;
    opcode <= row_opcode[0];
    funct <= row_funct[0];
    word = '0;
    for (int n = 0; n < 4 && word == '0; n++) begin
      @(negedge clk);
      word = output_word();
    end
    compare_field("RESET", "first word", int'(FETCH_WORD), int'(word));
    while (!ir_write) begin
      @(negedge clk);
    end
    finish_test("RESET");

    for (int i = 0; i < NUM_ROWS; i++) begin
      // Decode edge of row i frees the inputs for the next row
      @(posedge clk);
      if (i + 1 < NUM_ROWS) begin
        opcode <= row_opcode[i + 1];
        funct <= row_funct[i + 1];
      end
      collect_window();
      compare_field(row_name[i], "ir_write spacing", 4 + row_len[i], win_cycles + 1);
      compare_field(row_name[i], "reg_write count", row_reg_writes[i], win_reg);
      compare_field(row_name[i], "pc_write count", row_pc_writes[i], win_pc);
      compare_field(row_name[i], "alu_out_write count", row_alu_writes[i], win_alu);
      compare_field(row_name[i], "alu_op", int'(row_alu_op[i]), int'(win_op));
      if (row_pc_writes[i] > 0) begin
        compare_field(row_name[i], "pc_source", int'(row_pc_source[i]), int'(win_pcs));
      end
      if (row_reg_writes[i] > 0) begin
        compare_field(row_name[i], "first writeback", int'(row_pair0[i]), int'(win_pair[0]));
      end
      if (row_reg_writes[i] > 1) begin
        compare_field(row_name[i], "second writeback", int'(row_pair1[i]), int'(win_pair[1]));
      end
      finish_test(row_name[i]);
    end

    compare_field("PROPS", "assertion failures", 0, DUT.u_props.violations);
    finish_test("PROPS");
    $display("%0d tests run, %0d passed, %0d failed", tests_run, tests_run - tests_failed,
             tests_failed);
    if (tests_failed == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
